//--- hdl/id_pkg.sv
// ------------------------------------------------
// Shared types of the instruction decode stage
// Vector typedefs, operand select enums, ALU ops
// and the RV32I major opcodes
// ------------------------------------------------

`default_nettype none

package id_pkg;

  // Data path and register file widths
  typedef logic [31:0] data_t;
  typedef logic [4:0]  reg_addr_t;

  // ------------------------------------------------
  // Major opcodes
  // ------------------------------------------------
  typedef logic [6:0] opcode_t;

  localparam opcode_t OPCODE_OP     = 7'h33;
  localparam opcode_t OPCODE_OP_IMM = 7'h13;
  localparam opcode_t OPCODE_LUI    = 7'h37;
  localparam opcode_t OPCODE_AUIPC  = 7'h17;
  localparam opcode_t OPCODE_JAL    = 7'h6f;
  localparam opcode_t OPCODE_JALR   = 7'h67;
  localparam opcode_t OPCODE_BRANCH = 7'h63;
  localparam opcode_t OPCODE_LOAD   = 7'h03;
  localparam opcode_t OPCODE_STORE  = 7'h23;

  // ------------------------------------------------
  // ALU control
  // ------------------------------------------------
  // Arithmetic and logic ops first, then branch compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Operand A source
  typedef enum logic [1:0] {
    OP_A_REG_A,
    OP_A_CURRPC,
    OP_A_ZERO
  } op_a_sel_e;

  // Operand B source
  typedef enum logic {
    OP_B_REG_B,
    OP_B_IMM
  } op_b_sel_e;

  // Immediate driven onto operand B
  typedef enum logic [2:0] {
    IMM_B_I,
    IMM_B_S,
    IMM_B_B,
    IMM_B_U,
    IMM_B_J,
    IMM_B_INCR_PC
  } imm_b_sel_e;

  // Memory access size
  typedef logic [1:0] lsu_type_t;

  localparam lsu_type_t LSU_WORD = 2'b00;
  localparam lsu_type_t LSU_HALF = 2'b01;
  localparam lsu_type_t LSU_BYTE = 2'b10;

endpackage

`default_nettype wire

//--- hdl/id_decoder.sv
// ------------------------------------------------
// RV32I instruction decoder
// Control selects, immediates, register addresses
// and illegal instruction detection
// ------------------------------------------------

`default_nettype none

module id_decoder import id_pkg::*; #(
  parameter bit Rv32e = 1'b0
) (
  input  data_t      instr_i,

  // ALU control
  output alu_op_e    alu_operator_o,
  output op_a_sel_e  op_a_sel_o,
  output op_b_sel_e  op_b_sel_o,
  output imm_b_sel_e imm_b_sel_o,

  // Sign-extended immediates
  output data_t      imm_i_o,
  output data_t      imm_s_o,
  output data_t      imm_b_o,
  output data_t      imm_u_o,
  output data_t      imm_j_o,

  // Register file
  output reg_addr_t  raddr_a_o,
  output reg_addr_t  raddr_b_o,
  output reg_addr_t  waddr_o,
  output logic       rf_we_o,

  // Memory access
  output logic       lsu_req_o,
  output logic       lsu_we_o,
  output lsu_type_t  lsu_type_o,

  // Instruction class
  output logic       branch_o,
  output logic       jump_o,
  output logic       illegal_o
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // Raw class flags before the illegal qualification
  logic       writes_rd;
  logic       uses_rs1;
  logic       uses_rs2;
  logic       lsu_req;
  logic       lsu_we;
  logic       branch;
  logic       jump;
  logic       illegal_op;
  logic       illegal_reg;

  // Shared funct3 map of OP and OP-IMM, alt picks SUB or SRA
  function automatic alu_op_e alu_op_from_funct3(logic [2:0] f3, logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Fixed field positions, driven for every instruction
  assign raddr_a_o = instr_i[19:15];
  assign raddr_b_o = instr_i[24:20];
  assign waddr_o   = instr_i[11:7];

  // ------------------------------------------------
  // Immediates
  // ------------------------------------------------
  assign imm_i_o = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
  assign imm_u_o = {instr_i[31:12], 12'b0};
  assign imm_j_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  // ------------------------------------------------
  // Opcode decode
  // ------------------------------------------------
  always_comb begin
    alu_operator_o = ALU_ADD;
    op_a_sel_o     = OP_A_REG_A;
    op_b_sel_o     = OP_B_IMM;
    imm_b_sel_o    = IMM_B_I;
    lsu_type_o     = LSU_WORD;
    writes_rd      = 1'b0;
    uses_rs1       = 1'b0;
    uses_rs2       = 1'b0;
    lsu_req        = 1'b0;
    lsu_we         = 1'b0;
    branch         = 1'b0;
    jump           = 1'b0;
    illegal_op     = 1'b0;

    case (opcode)
      OPCODE_OP: begin
        writes_rd      = 1'b1;
        uses_rs1       = 1'b1;
        uses_rs2       = 1'b1;
        op_b_sel_o     = OP_B_REG_B;
        alu_operator_o = alu_op_from_funct3(funct3, funct7[5]);
        // Only ADD/SUB and SRL/SRA have an alternate funct7
        if (funct7 == 7'h20) begin
          illegal_op = (funct3 != 3'b000) && (funct3 != 3'b101);
        end else begin
          illegal_op = (funct7 != 7'h00);
        end
      end
      OPCODE_OP_IMM: begin
        writes_rd      = 1'b1;
        uses_rs1       = 1'b1;
        alu_operator_o = alu_op_from_funct3(funct3, (funct3 == 3'b101) & funct7[5]);
        // Shift amounts carry a funct7 field
        if (funct3 == 3'b001) begin
          illegal_op = (funct7 != 7'h00);
        end else if (funct3 == 3'b101) begin
          illegal_op = (funct7 != 7'h00) && (funct7 != 7'h20);
        end
      end
      OPCODE_LUI: begin
        writes_rd   = 1'b1;
        op_a_sel_o  = OP_A_ZERO;
        imm_b_sel_o = IMM_B_U;
      end
      OPCODE_AUIPC: begin
        writes_rd   = 1'b1;
        op_a_sel_o  = OP_A_CURRPC;
        imm_b_sel_o = IMM_B_U;
      end
      OPCODE_JAL, OPCODE_JALR: begin
        // Link value is PC + 4
        writes_rd   = 1'b1;
        jump        = 1'b1;
        op_a_sel_o  = OP_A_CURRPC;
        imm_b_sel_o = IMM_B_INCR_PC;
        if (opcode == OPCODE_JALR) begin
          uses_rs1   = 1'b1;
          illegal_op = (funct3 != 3'b000);
        end
      end
      OPCODE_BRANCH: begin
        branch      = 1'b1;
        uses_rs1    = 1'b1;
        uses_rs2    = 1'b1;
        op_b_sel_o  = OP_B_REG_B;
        imm_b_sel_o = IMM_B_B;
        case (funct3)
          3'b000:  alu_operator_o = ALU_EQ;
          3'b001:  alu_operator_o = ALU_NE;
          3'b100:  alu_operator_o = ALU_LT;
          3'b101:  alu_operator_o = ALU_GE;
          3'b110:  alu_operator_o = ALU_LTU;
          3'b111:  alu_operator_o = ALU_GEU;
          default: illegal_op     = 1'b1;
        endcase
      end
      OPCODE_LOAD, OPCODE_STORE: begin
        lsu_req  = 1'b1;
        uses_rs1 = 1'b1;
        case (funct3[1:0])
          2'b00:   lsu_type_o = LSU_BYTE;
          2'b01:   lsu_type_o = LSU_HALF;
          default: lsu_type_o = LSU_WORD;
        endcase
        if (opcode == OPCODE_STORE) begin
          lsu_we      = 1'b1;
          uses_rs2    = 1'b1;
          imm_b_sel_o = IMM_B_S;
          illegal_op  = funct3[2] | (funct3[1:0] == 2'b11);
        end else begin
          // Unsigned variants exist for byte and half only
          writes_rd  = 1'b1;
          illegal_op = (funct3[1:0] == 2'b11) | (funct3[2] & funct3[1]);
        end
      end
      default: illegal_op = 1'b1;
    endcase
  end

  // RV32E has 16 registers, upper half of the index space is illegal
  assign illegal_reg = Rv32e & ((uses_rs1 & instr_i[19]) | (uses_rs2 & instr_i[24]) |
                                (writes_rd & instr_i[11]));

  assign illegal_o = illegal_op | illegal_reg;

  // An illegal instruction has no side effects
  assign rf_we_o   = writes_rd & (waddr_o != '0) & ~illegal_o;
  assign lsu_req_o = lsu_req & ~illegal_o;
  assign lsu_we_o  = lsu_we & ~illegal_o;
  assign branch_o  = branch & ~illegal_o;
  assign jump_o    = jump & ~illegal_o;

endmodule

`default_nettype wire

//--- hdl/id_operand_mux.sv
// ------------------------------------------------
// ALU operand selection
// Operand B immediate mux, operand A and B muxes
// ------------------------------------------------

`default_nettype none

module id_operand_mux import id_pkg::*; (
  // Selects from the decoder
  input  op_a_sel_e  op_a_sel_i,
  input  op_b_sel_e  op_b_sel_i,
  input  imm_b_sel_e imm_b_sel_i,

  // Decoded immediates
  input  data_t      imm_i_i,
  input  data_t      imm_s_i,
  input  data_t      imm_b_i,
  input  data_t      imm_u_i,
  input  data_t      imm_j_i,

  // Data sources
  input  data_t      pc_i,
  input  data_t      rf_rdata_a_i,
  input  data_t      rf_rdata_b_i,

  output data_t      alu_operand_a_o,
  output data_t      alu_operand_b_o
);

  // No compressed instructions, the PC always steps by a word
  localparam data_t PcIncr = 32'h4;

  data_t imm_b;

  // Immediate for operand B
  always_comb begin
    case (imm_b_sel_i)
      IMM_B_I:       imm_b = imm_i_i;
      IMM_B_S:       imm_b = imm_s_i;
      IMM_B_B:       imm_b = imm_b_i;
      IMM_B_U:       imm_b = imm_u_i;
      IMM_B_J:       imm_b = imm_j_i;
      IMM_B_INCR_PC: imm_b = PcIncr;
      default:       imm_b = PcIncr;
    endcase
  end

  // Operand A from register, PC or zero
  always_comb begin
    case (op_a_sel_i)
      OP_A_REG_A:  alu_operand_a_o = rf_rdata_a_i;
      OP_A_CURRPC: alu_operand_a_o = pc_i;
      default:     alu_operand_a_o = '0;
    endcase
  end

  // Operand B from register or immediate
  assign alu_operand_b_o = (op_b_sel_i == OP_B_IMM) ? imm_b : rf_rdata_b_i;

endmodule

`default_nettype wire

//--- hdl/id_controller.sv
// ------------------------------------------------
// ID/EX stage controller
// Two-state FSM, memory/branch/jump stalls,
// branch and jump set, LSU request and done
// ------------------------------------------------

`default_nettype none

module id_controller (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic instr_valid_i,

  // Instruction class from the decoder
  input  logic lsu_req_dec_i,
  input  logic branch_dec_i,
  input  logic jump_dec_i,
  input  logic rf_we_dec_i,
  input  logic illegal_i,

  // From EX and LSU
  input  logic branch_decision_i,
  input  logic lsu_resp_valid_i,

  output logic lsu_req_o,
  output logic rf_we_o,
  output logic branch_set_o,
  output logic jump_set_o,
  output logic illegal_insn_o,
  output logic instr_done_o
);

  typedef enum logic {
    FIRST_CYCLE,
    MULTI_CYCLE
  } id_fsm_e;

  id_fsm_e id_fsm_q, id_fsm_d;

  logic first_cycle;
  logic multicycle_done;
  logic stall_mem;
  logic stall_branch;
  logic stall_jump;
  logic stall_id;
  logic branch_set_d, branch_set_q;
  logic jump_set_raw;
  logic set_done_d, set_done_q;

  // ------------------------------------------------
  // ID/EX state machine
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_fsm_q <= FIRST_CYCLE;
    end else begin
      id_fsm_q <= id_fsm_d;
    end
  end

  // Loads and stores wait for the response, everything else needs one extra cycle
  assign multicycle_done = lsu_req_dec_i ? lsu_resp_valid_i : 1'b1;

  always_comb begin
    id_fsm_d     = id_fsm_q;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;
    branch_set_d = 1'b0;
    jump_set_raw = 1'b0;

    if (instr_valid_i) begin
      case (id_fsm_q)
        FIRST_CYCLE: begin
          if (lsu_req_dec_i) begin
            id_fsm_d = MULTI_CYCLE;
          end else if (branch_dec_i) begin
            // Not-taken branch finishes here
            id_fsm_d     = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
            stall_branch = branch_decision_i;
            branch_set_d = branch_decision_i;
          end else if (jump_dec_i) begin
            id_fsm_d     = MULTI_CYCLE;
            stall_jump   = 1'b1;
            jump_set_raw = 1'b1;
          end
        end
        MULTI_CYCLE: begin
          if (multicycle_done) begin
            id_fsm_d = FIRST_CYCLE;
          end
        end
        default: id_fsm_d = FIRST_CYCLE;
      endcase
    end
  end

  // ------------------------------------------------
  // Stalls and done
  // ------------------------------------------------
  assign first_cycle = instr_valid_i & (id_fsm_q == FIRST_CYCLE);

  // Memory ops always stall their request cycle, then until the response
  assign stall_mem = instr_valid_i & lsu_req_dec_i & (~lsu_resp_valid_i | first_cycle);
  assign stall_id  = stall_mem | stall_branch | stall_jump;

  assign instr_done_o   = instr_valid_i & ~stall_id;
  assign lsu_req_o      = first_cycle & lsu_req_dec_i;
  assign rf_we_o        = rf_we_dec_i & instr_done_o;
  assign illegal_insn_o = instr_valid_i & illegal_i;

  // ------------------------------------------------
  // Branch and jump set
  // ------------------------------------------------
  // Branch set is the decision flopped into the second cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      branch_set_q <= 1'b0;
      set_done_q   <= 1'b0;
    end else begin
      branch_set_q <= branch_set_d;
      set_done_q   <= set_done_d;
    end
  end

  // Remember a set until the instruction leaves the stage
  assign set_done_d = (branch_set_q | jump_set_raw | set_done_q) & ~instr_done_o;

  assign branch_set_o = branch_set_q & ~set_done_q;
  assign jump_set_o   = jump_set_raw & ~set_done_q;

endmodule

`default_nettype wire

//--- hdl/id_stage.sv
// ------------------------------------------------
// Instruction decode stage top level
// Decoder, operand selection and controller
// ------------------------------------------------

`default_nettype none

module id_stage import id_pkg::*; #(
  parameter bit Rv32e = 1'b0
) (
  input  logic      clk_i,
  input  logic      rst_ni,

  // From the IF-ID register
  input  logic      instr_valid_i,
  input  data_t     instr_i,
  input  data_t     pc_i,

  // Register file
  output reg_addr_t rf_raddr_a_o,
  input  data_t     rf_rdata_a_i,
  output reg_addr_t rf_raddr_b_o,
  input  data_t     rf_rdata_b_i,
  output reg_addr_t rf_waddr_o,
  output logic      rf_we_o,

  // ALU
  output alu_op_e   alu_operator_o,
  output data_t     alu_operand_a_o,
  output data_t     alu_operand_b_o,
  input  logic      branch_decision_i,

  // LSU
  output logic      lsu_req_o,
  output logic      lsu_we_o,
  output lsu_type_t lsu_type_o,
  output data_t     lsu_wdata_o,
  input  logic      lsu_resp_valid_i,

  // Control flow and status
  output logic      branch_set_o,
  output logic      jump_set_o,
  output logic      illegal_insn_o,
  output logic      instr_done_o
);

  // Decoder to operand mux
  op_a_sel_e  op_a_sel;
  op_b_sel_e  op_b_sel;
  imm_b_sel_e imm_b_sel;
  data_t      imm_i, imm_s, imm_b, imm_u, imm_j;

  // Decoder to controller
  logic       lsu_req_dec;
  logic       branch_dec;
  logic       jump_dec;
  logic       rf_we_dec;
  logic       illegal_dec;

  // Store data comes straight from read port B
  assign lsu_wdata_o = rf_rdata_b_i;

  id_decoder #(
    .Rv32e(Rv32e)
  ) i_decoder (
    .instr_i       (instr_i),
    .alu_operator_o(alu_operator_o),
    .op_a_sel_o    (op_a_sel),
    .op_b_sel_o    (op_b_sel),
    .imm_b_sel_o   (imm_b_sel),
    .imm_i_o       (imm_i),
    .imm_s_o       (imm_s),
    .imm_b_o       (imm_b),
    .imm_u_o       (imm_u),
    .imm_j_o       (imm_j),
    .raddr_a_o     (rf_raddr_a_o),
    .raddr_b_o     (rf_raddr_b_o),
    .waddr_o       (rf_waddr_o),
    .rf_we_o       (rf_we_dec),
    .lsu_req_o     (lsu_req_dec),
    .lsu_we_o      (lsu_we_o),
    .lsu_type_o    (lsu_type_o),
    .branch_o      (branch_dec),
    .jump_o        (jump_dec),
    .illegal_o     (illegal_dec)
  );

  id_operand_mux i_operand_mux (
    .op_a_sel_i     (op_a_sel),
    .op_b_sel_i     (op_b_sel),
    .imm_b_sel_i    (imm_b_sel),
    .imm_i_i        (imm_i),
    .imm_s_i        (imm_s),
    .imm_b_i        (imm_b),
    .imm_u_i        (imm_u),
    .imm_j_i        (imm_j),
    .pc_i           (pc_i),
    .rf_rdata_a_i   (rf_rdata_a_i),
    .rf_rdata_b_i   (rf_rdata_b_i),
    .alu_operand_a_o(alu_operand_a_o),
    .alu_operand_b_o(alu_operand_b_o)
  );

  id_controller i_controller (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_valid_i    (instr_valid_i),
    .lsu_req_dec_i    (lsu_req_dec),
    .branch_dec_i     (branch_dec),
    .jump_dec_i       (jump_dec),
    .rf_we_dec_i      (rf_we_dec),
    .illegal_i        (illegal_dec),
    .branch_decision_i(branch_decision_i),
    .lsu_resp_valid_i (lsu_resp_valid_i),
    .lsu_req_o        (lsu_req_o),
    .rf_we_o          (rf_we_o),
    .branch_set_o     (branch_set_o),
    .jump_set_o       (jump_set_o),
    .illegal_insn_o   (illegal_insn_o),
    .instr_done_o     (instr_done_o)
  );

endmodule

`default_nettype wire

//--- bench/id_stage_checker.sv
// ------------------------------------------------
// Concurrent assertions on the decode stage
// handshake and control outputs, bound to id_stage
// ------------------------------------------------

`default_nettype none

module id_stage_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic instr_valid_i,
  input logic lsu_req_i,
  input logic instr_done_i,
  input logic branch_set_i
);

  // Failures seen so far, read by the testbench summary
  int fail_count = 0;

  // A memory request needs an instruction in the stage
  a_req_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_req_i |-> instr_valid_i)
  else begin
    $error("lsu_req_o high without instr_valid_i");
    fail_count++;
  end

  // Done only for a valid instruction
  a_done_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_done_i |-> instr_valid_i)
  else begin
    $error("instr_done_o high without instr_valid_i");
    fail_count++;
  end

  // Branch set is a single-cycle pulse
  a_branch_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    branch_set_i |=> !branch_set_i)
  else begin
    $error("branch_set_o high in two consecutive cycles");
    fail_count++;
  end

  // Memory ops never finish in their request cycle
  a_req_not_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(lsu_req_i && instr_done_i))
  else begin
    $error("lsu_req_o and instr_done_o high in the same cycle");
    fail_count++;
  end

endmodule

bind id_stage id_stage_checker i_checker (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .instr_valid_i(instr_valid_i),
  .lsu_req_i    (lsu_req_o),
  .instr_done_i (instr_done_o),
  .branch_set_i (branch_set_o)
);

`default_nettype wire

//--- bench/id_stage_monitor.sv
// ------------------------------------------------
// Decode stage monitor
// Tracks pulses per case, compares at the done cycle
// ------------------------------------------------

`default_nettype none

module id_stage_monitor (
  input  logic        clk_i,
  input  logic        case_active_i,
  input  int          case_num_i,

  // Stimulus that some checks refer to
  input  logic [31:0] instr_i,
  input  logic [31:0] rdata_b_i,

  // Expected values of the current case
  input  logic [3:0]  exp_alu_op_i,
  input  logic [31:0] exp_op_a_i,
  input  logic [31:0] exp_op_b_i,
  input  logic [4:0]  exp_waddr_i,
  input  logic        exp_we_i,
  input  logic        exp_lsu_req_i,
  input  logic        exp_lsu_we_i,
  input  logic [1:0]  exp_lsu_type_i,
  input  logic        exp_bset_i,
  input  logic        exp_jset_i,
  input  logic        exp_illegal_i,
  input  int          exp_cycles_i,

  // DUT outputs
  input  logic [4:0]  rf_raddr_a_i,
  input  logic [4:0]  rf_raddr_b_i,
  input  logic [3:0]  alu_operator_i,
  input  logic [31:0] alu_operand_a_i,
  input  logic [31:0] alu_operand_b_i,
  input  logic [4:0]  rf_waddr_i,
  input  logic        rf_we_i,
  input  logic        lsu_req_i,
  input  logic        lsu_we_i,
  input  logic [1:0]  lsu_type_i,
  input  logic [31:0] lsu_wdata_i,
  input  logic        branch_set_i,
  input  logic        jump_set_i,
  input  logic        illegal_insn_i,
  input  logic        instr_done_i,

  output int          errors_o,
  output int          cases_o
);

  int error_count = 0;
  int case_count  = 0;

  // Per-case history since valid rose
  int cycle;
  int req_count;
  int we_count;
  int bset_count;
  int jset_count;

  assign errors_o = error_count;
  assign cases_o  = case_count;

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_done();
    int errs_before;
    errs_before = error_count;
    check_value("instr_done_o cycle", cycle, exp_cycles_i);
    check_value("illegal_insn_o", illegal_insn_i, exp_illegal_i);
    check_value("rf_we_o", rf_we_i, exp_we_i);
    // rf_we_o only ever in the done cycle
    check_value("rf_we_o cycles", we_count, exp_we_i);
    check_value("lsu_req_o pulses", req_count, exp_lsu_req_i);
    check_value("lsu_we_o", lsu_we_i, exp_lsu_we_i);
    check_value("branch_set_o pulses", bset_count, exp_bset_i);
    check_value("jump_set_o pulses", jset_count, exp_jset_i);
    check_value("lsu_wdata_o", lsu_wdata_i, rdata_b_i);
    if (exp_we_i) begin
      check_value("rf_waddr_o", rf_waddr_i, exp_waddr_i);
    end
    if (exp_lsu_req_i) begin
      check_value("lsu_type_o", lsu_type_i, exp_lsu_type_i);
    end
    // Operands of an illegal instruction are don't care
    if (!exp_illegal_i) begin
      // rs1 and rs2 sit at the same bits in every RV32I format
      check_value("rf_raddr_a_o", rf_raddr_a_i, instr_i[19:15]);
      check_value("rf_raddr_b_o", rf_raddr_b_i, instr_i[24:20]);
      check_value("alu_operator_o", alu_operator_i, exp_alu_op_i);
      check_value("alu_operand_a_o", alu_operand_a_i, exp_op_a_i);
      check_value("alu_operand_b_o", alu_operand_b_i, exp_op_b_i);
    end
    case_count++;
    if (error_count == errs_before) begin
      $display("case %0d instr %08h: ok", case_num_i, instr_i);
    end else begin
      $display("case %0d instr %08h: %0d mismatches", case_num_i, instr_i,
               error_count - errs_before);
    end
  endtask

  // Outputs are settled half a cycle after the drive point
  always @(negedge clk_i) begin
    if (!case_active_i) begin
      cycle      = 0;
      req_count  = 0;
      we_count   = 0;
      bset_count = 0;
      jset_count = 0;
    end else begin
      req_count  += lsu_req_i;
      we_count   += rf_we_i;
      bset_count += branch_set_i;
      jset_count += jump_set_i;
      if (instr_done_i) begin
        compare_done();
      end
      cycle++;
    end
  end

endmodule

`default_nettype wire

//--- bench/id_stage_tb.sv
// ------------------------------------------------
// Decode stage testbench top
// Clock and reset, case file reader, stimulus
// and the closing summary
// ------------------------------------------------

`default_nettype none

module id_stage_tb import id_pkg::*; ();

  localparam int    ClkPeriod   = 10;
  localparam int    ResetCycles = 4;
  localparam int    DoneTimeout = 20;
  localparam string CaseFile    = "bench/id_stage_cases.txt";

  logic clk;
  logic rst_n;

  // DUT inputs
  logic  instr_valid;
  data_t instr;
  data_t pc;
  data_t rdata_a;
  data_t rdata_b;
  logic  branch_decision;
  logic  lsu_resp_valid;

  // DUT outputs
  reg_addr_t raddr_a;
  reg_addr_t raddr_b;
  reg_addr_t waddr;
  logic      rf_we;
  alu_op_e   alu_operator;
  data_t     operand_a;
  data_t     operand_b;
  logic      lsu_req;
  logic      lsu_we;
  lsu_type_t lsu_type;
  data_t     lsu_wdata;
  logic      branch_set;
  logic      jump_set;
  logic      illegal_insn;
  logic      instr_done;

  // Current case and its expected results
  logic        case_active;
  int          case_num;
  int          resp_delay;
  logic [31:0] fields [18];
  logic [3:0]  exp_alu_op;
  data_t       exp_op_a;
  data_t       exp_op_b;
  reg_addr_t   exp_waddr;
  logic        exp_we;
  logic        exp_lsu_req;
  logic        exp_lsu_we;
  lsu_type_t   exp_lsu_type;
  logic        exp_bset;
  logic        exp_jset;
  logic        exp_illegal;
  int          exp_cycles;
  int          mon_errors;
  int          mon_cases;

  // Rv32e set so register indices of 16 and up are illegal
  id_stage #(
    .Rv32e(1'b1)
  ) i_dut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .instr_valid_i    (instr_valid),
    .instr_i          (instr),
    .pc_i             (pc),
    .rf_raddr_a_o     (raddr_a),
    .rf_rdata_a_i     (rdata_a),
    .rf_raddr_b_o     (raddr_b),
    .rf_rdata_b_i     (rdata_b),
    .rf_waddr_o       (waddr),
    .rf_we_o          (rf_we),
    .alu_operator_o   (alu_operator),
    .alu_operand_a_o  (operand_a),
    .alu_operand_b_o  (operand_b),
    .branch_decision_i(branch_decision),
    .lsu_req_o        (lsu_req),
    .lsu_we_o         (lsu_we),
    .lsu_type_o       (lsu_type),
    .lsu_wdata_o      (lsu_wdata),
    .lsu_resp_valid_i (lsu_resp_valid),
    .branch_set_o     (branch_set),
    .jump_set_o       (jump_set),
    .illegal_insn_o   (illegal_insn),
    .instr_done_o     (instr_done)
  );

  id_stage_monitor i_monitor (
    .clk_i          (clk),
    .case_active_i  (case_active),
    .case_num_i     (case_num),
    .instr_i        (instr),
    .rdata_b_i      (rdata_b),
    .exp_alu_op_i   (exp_alu_op),
    .exp_op_a_i     (exp_op_a),
    .exp_op_b_i     (exp_op_b),
    .exp_waddr_i    (exp_waddr),
    .exp_we_i       (exp_we),
    .exp_lsu_req_i  (exp_lsu_req),
    .exp_lsu_we_i   (exp_lsu_we),
    .exp_lsu_type_i (exp_lsu_type),
    .exp_bset_i     (exp_bset),
    .exp_jset_i     (exp_jset),
    .exp_illegal_i  (exp_illegal),
    .exp_cycles_i   (exp_cycles),
    .rf_raddr_a_i   (raddr_a),
    .rf_raddr_b_i   (raddr_b),
    .alu_operator_i (alu_operator),
    .alu_operand_a_i(operand_a),
    .alu_operand_b_i(operand_b),
    .rf_waddr_i     (waddr),
    .rf_we_i        (rf_we),
    .lsu_req_i      (lsu_req),
    .lsu_we_i       (lsu_we),
    .lsu_type_i     (lsu_type),
    .lsu_wdata_i    (lsu_wdata),
    .branch_set_i   (branch_set),
    .jump_set_i     (jump_set),
    .illegal_insn_i (illegal_insn),
    .instr_done_i   (instr_done),
    .errors_o       (mon_errors),
    .cases_o        (mon_cases)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Comment and blank lines carry no case
  function automatic bit is_case_line(string s);
    if (s.len() == 0) begin
      return 1'b0;
    end
    return (s[0] != "#") && (s[0] != "\n");
  endfunction

  // ------------------------------------------------
  // One case, entered and left 1 unit after a rising edge
  // ------------------------------------------------
  task automatic run_case(output bit timed_out);
    int cycle;
    bit done;
    cycle     = 0;
    done      = 1'b0;
    timed_out = 1'b0;
    instr           = fields[0];
    pc              = fields[1];
    rdata_a         = fields[2];
    rdata_b         = fields[3];
    branch_decision = fields[4][0];
    resp_delay      = fields[5];
    exp_alu_op      = fields[6][3:0];
    exp_op_a        = fields[7];
    exp_op_b        = fields[8];
    exp_waddr       = fields[9][4:0];
    exp_we          = fields[10][0];
    exp_lsu_req     = fields[11][0];
    exp_lsu_we      = fields[12][0];
    exp_lsu_type    = fields[13][1:0];
    exp_bset        = fields[14][0];
    exp_jset        = fields[15][0];
    exp_illegal     = fields[16][0];
    exp_cycles      = fields[17];
    case_num++;
    case_active = 1'b1;
    instr_valid = 1'b1;
    while (!done && !timed_out) begin
      // Response strobe in the cycle given by the case, none for delay 0
      lsu_resp_valid = (resp_delay != 0) && (cycle == resp_delay);
      @(negedge clk);
      if (instr_done) begin
        done = 1'b1;
      end else if (cycle >= DoneTimeout) begin
        timed_out = 1'b1;
        $display("Timeout: case %0d saw no instr_done_o within %0d cycles",
                 case_num, DoneTimeout);
      end
      @(posedge clk);
      #1;
      cycle++;
    end
    // One idle cycle lets the FSM settle before the next case
    instr_valid     = 1'b0;
    case_active     = 1'b0;
    lsu_resp_valid  = 1'b0;
    branch_decision = 1'b0;
    @(posedge clk);
    #1;
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------
  initial begin
    int    fd;
    int    n;
    string line;
    bit    timed_out;
    bit    aborted;
    int    assert_fails;

    rst_n           = 1'b0;
    instr_valid     = 1'b0;
    instr           = '0;
    pc              = '0;
    rdata_a         = '0;
    rdata_b         = '0;
    branch_decision = 1'b0;
    lsu_resp_valid  = 1'b0;
    case_active     = 1'b0;
    case_num        = 0;
    aborted         = 1'b0;

    fd = $fopen(CaseFile, "r");
    if (fd == 0) begin
      $display("Could not open the case file %s", CaseFile);
      aborted = 1'b1;
    end

    repeat (ResetCycles) @(posedge clk);
    #1;
    rst_n = 1'b1;

    while (!aborted && !$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && is_case_line(line)) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    fields[0], fields[1], fields[2], fields[3], fields[4], fields[5],
                    fields[6], fields[7], fields[8], fields[9], fields[10], fields[11],
                    fields[12], fields[13], fields[14], fields[15], fields[16], fields[17]);
        if (n != 18) begin
          $display("Malformed line in the case file: %s", line);
          aborted = 1'b1;
        end else begin
          run_case(timed_out);
          aborted = timed_out;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    assert_fails = i_dut.i_checker.fail_count;
    $display("Summary: %0d of %0d cases checked, %0d mismatches, %0d assertion failures",
             mon_cases, case_num, mon_errors, assert_fails);
    if (aborted || mon_errors != 0 || assert_fails != 0 || mon_cases != case_num ||
        case_num == 0) begin
      $display("Test failed");
    end else begin
      $display("Test completed successfully");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
hdl/id_pkg.sv
hdl/id_decoder.sv
hdl/id_operand_mux.sv
hdl/id_controller.sv
hdl/id_stage.sv
bench/id_stage_checker.sv
bench/id_stage_monitor.sv
bench/id_stage_tb.sv

//--- bench/id_stage_cases.txt
# instr pc rdata_a rdata_b bdec delay alu op_a op_b waddr we req lsu_we type bset jset ill cycles
# All columns hex; delay is the response cycle of a load or store, cycles is the done cycle
002082b3 00001000 00000011 00000022 0 0 0 00000011 00000022 05 1 0 0 0 0 0 0 0
40418333 00001004 00000100 00000001 0 0 1 00000100 00000001 06 1 0 0 0 0 0 0 0
009423b3 00001008 ffffffff 00000001 0 0 8 ffffffff 00000001 07 1 0 0 0 0 0 0 0
40c5d533 0000100c 80000000 00000004 0 0 7 80000000 00000004 0a 1 0 0 0 0 0 0 0
fff74693 00001010 0000f0f0 12345678 0 0 2 0000f0f0 ffffffff 0d 1 0 0 0 0 0 0 0
00508013 00001014 00000007 00000000 0 0 0 00000007 00000005 00 0 0 0 0 0 0 0 0
abcde7b7 00001018 11111111 22222222 0 0 0 00000000 abcde000 0f 1 0 0 0 0 0 0 0
00012097 00002000 33333333 44444444 0 0 0 00002000 00012000 01 1 0 0 0 0 0 0 0
00208463 00003000 00000005 00000006 0 0 a 00000005 00000006 00 0 0 0 0 0 0 0 0
00419463 00003004 00000001 00000002 1 0 b 00000001 00000002 00 0 0 0 0 1 0 0 1
0062c463 00003008 fffffff0 00000010 1 0 c fffffff0 00000010 00 0 0 0 0 1 0 0 1
010000ef 00004000 55555555 66666666 0 0 0 00004000 00000004 01 1 0 0 0 0 1 0 1
000302e7 00005000 00008000 00000000 0 0 0 00005000 00000004 05 1 0 0 0 0 1 0 1
00442383 00006000 00010000 deadbeef 0 1 0 00010000 00000004 07 1 1 0 0 0 0 0 1
fff50483 00006004 00020000 00000000 0 3 0 00020000 ffffffff 09 1 1 0 2 0 0 0 3
00b62423 00006008 00030000 cafef00d 0 2 0 00030000 00000008 00 0 1 1 0 0 0 0 2
fed71e23 0000600c 00040010 0000beef 0 5 0 00040010 fffffffc 00 0 1 1 1 0 0 0 5
0000007f 00007000 00000001 00000002 0 0 0 00000000 00000000 00 0 0 0 0 0 0 1 0
0000000b 00007004 00000003 00000004 0 0 0 00000000 00000000 00 0 0 0 0 0 0 1 0
00208833 00007008 00000005 00000006 0 0 0 00000000 00000000 00 0 0 0 0 0 0 1 0
0008a083 0000700c 00000007 00000008 0 0 0 00000000 00000000 00 0 0 0 0 0 0 1 0
